/* source/fetch_pkg.sv */
// shared types for the fetch front end, imported by every rtl module and the testbench
package fetch_pkg;

	// address and pc word
	typedef logic [31:0] xlen_t;

	// raw instruction word, never decoded here
	typedef logic [31:0] insn_t;

	// one fetched instruction with its pc
	// unit stored in the buffer and handed to decode
	typedef struct packed {
		xlen_t pc;
		insn_t insn;
	} fetch_item_t;

	// apb request bundle, driven by the bus master
	typedef struct packed {
		logic  psel;
		logic  penable;
		logic  pwrite;
		xlen_t paddr;
		insn_t pwdata;
	} apb_req_t;

	// apb response bundle
	// pready stays high, no wait states
	typedef struct packed {
		insn_t prdata;
		logic  pready;
		logic  pslverr;
	} apb_rsp_t;

	// fetch controller states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_FLUSH
	} fetch_state_t;

	// reset pc unless the top level overrides it
	localparam xlen_t DEFAULT_BOOT_PC = 32'h0000_0000;

endpackage

/* source/insn_mem.sv */
// instruction memory, loaded and read back over apb, with a registered fetch read port
`timescale 1ns/1ps

module insn_mem #(
	parameter int MEM_WORDS = 256
) (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  fetch_pkg::apb_req_t    apb_req_i,
	output fetch_pkg::apb_rsp_t    apb_rsp_o,
	input  logic                   rd_en_i,
	input  fetch_pkg::xlen_t       rd_pc_i,
	output fetch_pkg::fetch_item_t rd_item_o
);

	import fetch_pkg::*;

	// word index width
	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	// first word index past the array
	localparam logic [29:0] WORD_LIMIT = 30'(MEM_WORDS);

	// storage
	insn_t mem [MEM_WORDS];

	logic             apb_access;
	logic             apb_bad;
	logic [IDX_W-1:0] apb_idx;
	logic             fetch_ok;
	logic [IDX_W-1:0] fetch_idx;

	// access phase of a transfer
	assign apb_access = apb_req_i.psel & apb_req_i.penable;

	// unaligned or past the end
	assign apb_bad = (apb_req_i.paddr[1:0] != 2'b00) ||
		(apb_req_i.paddr[31:2] >= WORD_LIMIT);

	// byte address to word index
	assign apb_idx = apb_req_i.paddr[IDX_W+1:2];

	// response path is combinational, completes in the access phase
	assign apb_rsp_o.pready  = 1'b1;
	assign apb_rsp_o.pslverr = apb_access & apb_bad;
	// bad address reads back as zero
	assign apb_rsp_o.prdata  = (apb_access && !apb_req_i.pwrite && !apb_bad) ?
		mem[apb_idx] : '0;

	// program load
	// erroneous writes are dropped
	always_ff @(posedge clk) begin
		if (apb_access && apb_req_i.pwrite && !apb_bad) begin
			mem[apb_idx] <= apb_req_i.pwdata;
		end
	end

	// fetch address decode, same rules as the bus side
	assign fetch_ok  = (rd_pc_i[1:0] == 2'b00) && (rd_pc_i[31:2] < WORD_LIMIT);
	assign fetch_idx = rd_pc_i[IDX_W+1:2];

	// one cycle fetch read
	// pc travels with the word so the buffer gets a complete item
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rd_item_o <= '0;
		end else if (rd_en_i) begin
			rd_item_o.pc <= rd_pc_i;
			// outside the array returns 0
			rd_item_o.insn <= fetch_ok ? mem[fetch_idx] : '0;
		end
	end

endmodule

/* source/pc_gen.sv */
// fetch program counter, steps by one word per issued fetch and reloads on a redirect
`timescale 1ns/1ps

module pc_gen #(
	parameter fetch_pkg::xlen_t BOOT_PC = fetch_pkg::DEFAULT_BOOT_PC
) (
	input  logic             clk,
	input  logic             arst_n_i,
	input  logic             issue_i,
	input  logic             redirect_i,
	input  fetch_pkg::xlen_t redirect_pc_i,
	output fetch_pkg::xlen_t pc_o
);

	import fetch_pkg::*;

	// fixed 32-bit instructions
	localparam xlen_t PC_STEP = 32'd4;

	xlen_t pc_q;

	// pc of the next fetch to issue
	assign pc_o = pc_q;

	// redirect wins over a same-cycle issue
	// controller never issues on a redirect cycle anyway
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q <= BOOT_PC;
		end else if (redirect_i) begin
			pc_q <= redirect_pc_i;
		end else if (issue_i) begin
			pc_q <= pc_q + PC_STEP;
		end
	end

endmodule

/* source/fetch_ctrl.sv */
// fetch control FSM: gates fetch issue on buffer room, tracks the in-flight read, handles flush
`timescale 1ns/1ps

module fetch_ctrl #(
	parameter int BUF_DEPTH = 8
) (
	input  logic                    clk,
	input  logic                    arst_n_i,
	input  logic                    fetch_en_i,
	input  logic                    redirect_i,
	input  logic [$clog2(BUF_DEPTH):0] free_slots_i,
	output logic                    issue_o,
	output logic                    rd_valid_o,
	output logic                    flush_o,
	output fetch_pkg::fetch_state_t state_o
);

	import fetch_pkg::*;

	localparam int CNT_W = $clog2(BUF_DEPTH) + 1;

	fetch_state_t     state_q;
	fetch_state_t     state_d;
	logic             in_flight_q;
	logic [CNT_W-1:0] pending;
	logic             room;
	logic             may_issue;

	// reads already on their way to the buffer, 0 or 1
	assign pending = {{(CNT_W-1){1'b0}}, in_flight_q};

	// a slot must stay free for the read still in flight
	assign room = free_slots_i > pending;

	// flush cycle doubles as the restart cycle when fetch stays enabled
	// so the new path is written two edges after the redirect
	assign may_issue = (state_q == ST_RUN) ||
		((state_q == ST_FLUSH) && fetch_en_i);

	// no issue on a redirect cycle, pc is being reloaded
	assign issue_o = may_issue && room && !redirect_i;

	// flush lasts exactly the redirect cycle
	assign flush_o = redirect_i;

	// in-flight data arriving on a redirect edge belongs to the old path
	assign rd_valid_o = in_flight_q & ~redirect_i;

	assign state_o = state_q;

	// next state
	always_comb begin
		state_d = state_q;
		unique case (state_q)
			ST_IDLE: begin
				if (redirect_i) begin
					state_d = ST_FLUSH;
				end else if (fetch_en_i) begin
					state_d = ST_RUN;
				end
			end
			ST_RUN: begin
				if (redirect_i) begin
					state_d = ST_FLUSH;
				end else if (!fetch_en_i) begin
					// issued read still completes
					state_d = ST_IDLE;
				end
			end
			ST_FLUSH: begin
				// back to back redirects stay here
				if (redirect_i) begin
					state_d = ST_FLUSH;
				end else if (fetch_en_i) begin
					state_d = ST_RUN;
				end else begin
					state_d = ST_IDLE;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	// state and in-flight tracking
	// memory answers one cycle after issue, so issue delayed is the read valid
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q     <= ST_IDLE;
			in_flight_q <= 1'b0;
		end else begin
			state_q     <= state_d;
			in_flight_q <= issue_o;
		end
	end

endmodule

/* source/fetch_buffer.sv */
// circular fetch buffer between memory and decode, round bits separate full from empty
`timescale 1ns/1ps

module fetch_buffer #(
	parameter int BUF_DEPTH = 8
) (
	input  logic                       clk,
	input  logic                       arst_n_i,
	input  logic                       flush_i,
	input  logic                       wr_en_i,
	input  fetch_pkg::fetch_item_t     wr_item_i,
	input  logic                       rd_ready_i,
	output logic                       rd_valid_o,
	output fetch_pkg::fetch_item_t     rd_item_o,
	output logic [$clog2(BUF_DEPTH):0] free_slots_o
);

	import fetch_pkg::*;

	// depth must be a power of two so the pointers wrap by themselves
	localparam int PTR_W = $clog2(BUF_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	fetch_item_t entries [BUF_DEPTH];

	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic             h_round;
	logic             t_round;
	logic             empty;
	logic             full;
	logic             push;
	logic             pop;
	logic [CNT_W-1:0] used;

	// same slot, same lap
	assign empty = (head == tail) && (h_round == t_round);
	// same slot, writer one lap ahead
	assign full  = (head == tail) && (h_round != t_round);

	// occupancy, round bit acts as the counter msb
	assign used = {t_round, tail} - {h_round, head};

	assign free_slots_o = CNT_W'(BUF_DEPTH) - used;

	// controller guarantees room, full check only as a guard
	assign push = wr_en_i & ~full;
	assign pop  = rd_valid_o & rd_ready_i;

	// head entry goes straight to decode
	assign rd_valid_o = ~empty;
	assign rd_item_o  = entries[head];

	// pointers and round bits
	// flush empties the buffer and wins over any push or pop
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			head    <= '0;
			tail    <= '0;
			h_round <= 1'b0;
			t_round <= 1'b0;
		end else if (flush_i) begin
			head    <= '0;
			tail    <= '0;
			h_round <= 1'b0;
			t_round <= 1'b0;
		end else begin
			// round bit flips when the pointer wraps
			if (push) begin
				{t_round, tail} <= {t_round, tail} + 1'b1;
			end
			if (pop) begin
				{h_round, head} <= {h_round, head} + 1'b1;
			end
		end
	end

	// entry storage, contents survive a flush
	always_ff @(posedge clk) begin
		if (push) begin
			entries[tail] <= wr_item_i;
		end
	end

endmodule

/* source/fetch_top.sv */
// fetch front end top level, joins memory, pc generator, controller and buffer
`timescale 1ns/1ps

module fetch_top #(
	parameter int               MEM_WORDS = 256,
	parameter int               BUF_DEPTH = 8,
	parameter fetch_pkg::xlen_t BOOT_PC   = fetch_pkg::DEFAULT_BOOT_PC
) (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  fetch_pkg::apb_req_t    apb_req_i,
	output fetch_pkg::apb_rsp_t    apb_rsp_o,
	input  logic                   fetch_en_i,
	input  logic                   redirect_i,
	input  fetch_pkg::xlen_t       redirect_pc_i,
	input  logic                   dec_ready_i,
	output logic                   dec_valid_o,
	output fetch_pkg::fetch_item_t dec_item_o
);

	import fetch_pkg::*;

	logic                     issue;
	logic                     rd_valid;
	logic                     flush;
	xlen_t                    pc;
	fetch_item_t              rd_item;
	logic [$clog2(BUF_DEPTH):0] free_slots;

	// program store and fetch read
	insn_mem #(
		.MEM_WORDS(MEM_WORDS)
	) i_insn_mem (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.apb_req_i(apb_req_i),
		.apb_rsp_o(apb_rsp_o),
		.rd_en_i  (issue),
		.rd_pc_i  (pc),
		.rd_item_o(rd_item)
	);

	// next fetch address
	pc_gen #(
		.BOOT_PC(BOOT_PC)
	) i_pc_gen (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.issue_i      (issue),
		.redirect_i   (redirect_i),
		.redirect_pc_i(redirect_pc_i),
		.pc_o         (pc)
	);

	// issue and flush sequencing
	fetch_ctrl #(
		.BUF_DEPTH(BUF_DEPTH)
	) i_fetch_ctrl (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.fetch_en_i  (fetch_en_i),
		.redirect_i  (redirect_i),
		.free_slots_i(free_slots),
		.issue_o     (issue),
		.rd_valid_o  (rd_valid),
		.flush_o     (flush),
		.state_o     ()
	);

	// decode side queue
	fetch_buffer #(
		.BUF_DEPTH(BUF_DEPTH)
	) i_fetch_buffer (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.flush_i     (flush),
		.wr_en_i     (rd_valid),
		.wr_item_i   (rd_item),
		.rd_ready_i  (dec_ready_i),
		.rd_valid_o  (dec_valid_o),
		.rd_item_o   (dec_item_o),
		.free_slots_o(free_slots)
	);

endmodule

/* verification/fetch_properties.sv */
// concurrent checks on the fetch front end ports and buffer status, bound into fetch_top
`timescale 1ns/1ps

module fetch_properties #(
	parameter int BUF_DEPTH = 8
) (
	input logic                       clk,
	input logic                       arst_n_i,
	input logic                       redirect_i,
	input logic                       dec_ready_i,
	input logic                       dec_valid_i,
	input fetch_pkg::fetch_item_t     dec_item_i,
	input fetch_pkg::apb_rsp_t        apb_rsp_i,
	input logic                       wr_en_i,
	input logic [$clog2(BUF_DEPTH):0] free_slots_i
);

	import fetch_pkg::*;

	// failed assertions so far, polled by the testbench
	int unsigned fail_count = 0;

	// stalled item must not change until decode takes it
	// a redirect may legally drop it
	property item_held_on_stall;
		@(posedge clk) disable iff (!arst_n_i)
		(dec_valid_i && !dec_ready_i && !redirect_i) |=> $stable(dec_item_i);
	endproperty

	assert property (item_held_on_stall) else begin
		$error("dec_item_o changed while decode was stalled");
		fail_count++;
	end

	// nothing valid straight out of reset
	assert property (@(posedge clk) $rose(arst_n_i) |-> !dec_valid_i) else begin
		$error("dec_valid_o high in the first cycle after reset");
		fail_count++;
	end

	// apb slave never inserts wait states
	assert property (@(posedge clk) apb_rsp_i.pready) else begin
		$error("pready dropped low");
		fail_count++;
	end

	// flush empties the buffer on the redirect edge
	assert property (@(posedge clk) disable iff (!arst_n_i) redirect_i |=> !dec_valid_i) else begin
		$error("dec_valid_o high in the cycle after a redirect");
		fail_count++;
	end

	// controller keeps a slot for every read in flight
	// a returning read never meets a full buffer
	assert property (@(posedge clk) disable iff (!arst_n_i) wr_en_i |-> free_slots_i != '0) else begin
		$error("fetched word arrived while the buffer was full");
		fail_count++;
	end

endmodule

bind fetch_top fetch_properties #(
	.BUF_DEPTH(BUF_DEPTH)
) i_fetch_properties (
	.clk         (clk),
	.arst_n_i    (arst_n_i),
	.redirect_i  (redirect_i),
	.dec_ready_i (dec_ready_i),
	.dec_valid_i (dec_valid_o),
	.dec_item_i  (dec_item_o),
	.apb_rsp_i   (apb_rsp_o),
	.wr_en_i     (rd_valid),
	.free_slots_i(free_slots)
);

/* verification/fetch_tb.sv */
// testbench for fetch_top: loads a program over apb, then consumes and checks fetched items
`timescale 1ns/1ps

module fetch_tb;

	import fetch_pkg::*;

	localparam int    MEM_WORDS = 64;
	localparam int    BUF_DEPTH = 8;
	localparam xlen_t BOOT_PC   = DEFAULT_BOOT_PC;

	logic        clk;
	logic        arst_n;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	logic        fetch_en;
	logic        redirect;
	xlen_t       redirect_pc;
	logic        dec_ready;
	logic        dec_valid;
	fetch_item_t dec_item;

	// reference model, program image and next expected pc
	insn_t       prog [MEM_WORDS];
	xlen_t       exp_pc;
	int unsigned accepted;
	// decode must see nothing while set
	logic        expect_quiet;
	integer      seed;

	fetch_top #(
		.MEM_WORDS(MEM_WORDS),
		.BUF_DEPTH(BUF_DEPTH),
		.BOOT_PC  (BOOT_PC)
	) i_fetch_top (
		.clk          (clk),
		.arst_n_i     (arst_n),
		.apb_req_i    (apb_req),
		.apb_rsp_o    (apb_rsp),
		.fetch_en_i   (fetch_en),
		.redirect_i   (redirect),
		.redirect_pc_i(redirect_pc),
		.dec_ready_i  (dec_ready),
		.dec_valid_o  (dec_valid),
		.dec_item_o   (dec_item)
	);

	always #5 clk = ~clk;

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	// stimulus changes 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// word the program image holds at a fetch address, zero outside the array
	function automatic insn_t word_at(input xlen_t pc);
		if (pc[1:0] != 2'b00 || pc[31:2] >= MEM_WORDS) begin
			return '0;
		end
		return prog[pc[31:2]];
	endfunction

	// setup phase, then access phase until pready
	task automatic apb_xfer(input logic write, input xlen_t addr, input insn_t wdata,
			output insn_t rdata, output logic slverr);
		int wait_cnt;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		next_cycle();
		apb_req.penable = 1'b1;
		wait_cnt = 0;
		@(negedge clk);
		while (!apb_rsp.pready) begin
			if (wait_cnt >= 16) begin
				$display("APB transfer to address %h never completed", addr);
				abort_run();
			end
			wait_cnt++;
			@(negedge clk);
		end
		rdata  = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		next_cycle();
		apb_req = '0;
	endtask

	task automatic apb_write(input xlen_t addr, input insn_t data, input logic exp_err);
		insn_t rdata;
		logic  slverr;
		apb_xfer(1'b1, addr, data, rdata, slverr);
		check_value("pslverr", 32'(exp_err), 32'(slverr));
	endtask

	task automatic apb_read(input xlen_t addr, input insn_t exp_data, input logic exp_err);
		insn_t rdata;
		logic  slverr;
		apb_xfer(1'b0, addr, '0, rdata, slverr);
		check_value("pslverr", 32'(exp_err), 32'(slverr));
		check_value("prdata", exp_data, rdata);
	endtask

	// one-cycle redirect pulse
	task automatic do_redirect(input xlen_t target);
		redirect    = 1'b1;
		redirect_pc = target;
		next_cycle();
		redirect = 1'b0;
	endtask

	task automatic wait_for_items(input int unsigned count, input int limit);
		int unsigned target;
		int          cycles;
		target = accepted + count;
		cycles = 0;
		while (accepted < target) begin
			if (cycles >= limit) begin
				$display("Timeout: decode took %0d of %0d items", accepted, target);
				abort_run();
			end
			cycles++;
			next_cycle();
		end
	endtask

	// valid low for a few cycles in a row, so no read is still in flight
	task automatic wait_drained(input int limit);
		int quiet;
		int cycles;
		quiet  = 0;
		cycles = 0;
		while (quiet < 4) begin
			if (cycles >= limit) begin
				$display("Timeout: buffer never drained after fetch disable");
				abort_run();
			end
			cycles++;
			@(negedge clk);
			quiet = dec_valid ? 0 : quiet + 1;
		end
		next_cycle();
	endtask

	// decode consumer model
	// negedge sampling, all DUT outputs settled
	always @(negedge clk) begin
		if (arst_n) begin
			if (expect_quiet) begin
				check_value("dec_valid_o", 32'd0, 32'(dec_valid));
			end
			// transfer happens on the coming edge
			if (dec_valid && dec_ready) begin
				check_value("dec_item_o.pc", exp_pc, dec_item.pc);
				check_value("dec_item_o.insn", word_at(exp_pc), dec_item.insn);
				exp_pc = exp_pc + 32'd4;
				accepted++;
			end
			// new path starts after anything taken this cycle
			if (redirect) begin
				exp_pc = redirect_pc;
			end
			if (i_fetch_top.i_fetch_properties.fail_count != 0) begin
				$display("A bound assertion on fetch_top failed");
				abort_run();
			end
		end
	end

	initial begin
		int rnd;
		seed         = 32'h237c;
		clk          = 1'b0;
		arst_n       = 1'b0;
		apb_req      = '0;
		fetch_en     = 1'b0;
		redirect     = 1'b0;
		redirect_pc  = '0;
		dec_ready    = 1'b0;
		exp_pc       = BOOT_PC;
		accepted     = 0;
		expect_quiet = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// program load and readback, fetch disabled so decode stays quiet
		for (int i = 0; i < MEM_WORDS; i++) begin
			prog[i] = $random(seed);
			apb_write(xlen_t'(i * 4), prog[i], 1'b0);
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			apb_read(xlen_t'(i * 4), prog[i], 1'b0);
		end
		// past the end and unaligned
		apb_write(xlen_t'(MEM_WORDS * 4), 32'hdead_beef, 1'b1);
		apb_read(xlen_t'(MEM_WORDS * 4), '0, 1'b1);
		apb_write(32'h0000_0006, 32'h1234_5678, 1'b1);
		apb_read(32'h0000_0006, '0, 1'b1);
		apb_read(32'h0000_0004, prog[1], 1'b0);

		// straight-line fetch, decode always ready
		expect_quiet = 1'b0;
		dec_ready    = 1'b1;
		fetch_en     = 1'b1;
		wait_for_items(24, 200);

		// redirect while streaming
		do_redirect(32'h0000_0080);
		wait_for_items(16, 200);

		// random back-pressure with long stalls and redirects mixed in
		for (int i = 0; i < 300; i++) begin
			if (i % 60 == 20) begin
				dec_ready = 1'b0;
				repeat (20) next_cycle();
			end else if (i % 60 == 45) begin
				rnd = $random(seed);
				do_redirect(xlen_t'(($unsigned(rnd) % (MEM_WORDS / 2)) * 4));
			end else begin
				rnd = $random(seed);
				dec_ready = rnd[0];
				next_cycle();
			end
		end
		dec_ready = 1'b1;
		wait_for_items(8, 100);

		// fetch off, buffer empties and stays empty
		fetch_en = 1'b0;
		wait_drained(50);
		expect_quiet = 1'b1;
		repeat (20) next_cycle();

		if (i_fetch_top.i_fetch_properties.fail_count != 0) begin
			$display("A bound assertion on fetch_top failed");
			$display("=== FAIL ===");
			$fatal(1, "simulation stopped on assertion failure");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

/* sim.f */
source/fetch_pkg.sv
source/insn_mem.sv
source/pc_gen.sv
source/fetch_ctrl.sv
source/fetch_buffer.sv
source/fetch_top.sv
verification/fetch_properties.sv
verification/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module fetch_tb -Mdir "$BUILD_DIR" -f sim.f
if [ $? -ne 0 ]; then
	echo "compile step returned an error"
	exit 1
fi

"./$BUILD_DIR/Vfetch_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
